/* tb.f */
+incdir+include
source/rv_pkg.sv
source/ctrl.sv
source/imm_gen.sv
source/reg_file.sv
source/exec_unit.sv
source/exec_core.sv
tests/clk_gen.sv
tests/tb_exec_core.sv

/* Makefile */
VERILATOR  := verilator
TOP        := tb_exec_core
FILELIST   := tb.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
PASS_MSG   := sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line shows up in stdout
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_exec_core.sv */
`default_nettype none

`include "rv_config.svh"

module tb_exec_core import rv_pkg::*; ();

    localparam int     PERIOD        = 100;
    localparam int     RESET_CYCLES  = 10;
    localparam int     NUM_INSTS     = 400;
    localparam int     IDLE_PCT      = 15;
    localparam longint WATCHDOG_TIME = longint'(RESET_CYCLES + 2 * NUM_INSTS + 20) * PERIOD;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG32  = 7'b0111011;
    localparam logic [6:0] OP_IMM32  = 7'b0011011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;

    typedef struct packed {
        xlen_t     pc;
        xlen_t     next_pc;
        logic      wen;
        reg_addr_t rd;
        xlen_t     data;
        logic      ebreak;
        logic      illegal;
    } retire_rec_t;

    logic      clk;
    logic      rst_n;
    inst_t     inst;
    logic      inst_valid;
    xlen_t     pc;
    logic      retire_valid;
    xlen_t     retire_pc;
    logic      retire_wen;
    reg_addr_t retire_rd;
    xlen_t     retire_data;
    logic      ebreak;
    logic      illegal;

    xlen_t       model_regs [`NUM_REGS];
    xlen_t       model_pc;
    retire_rec_t pending [$];
    int          issued;
    int          checked;

    clk_gen #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    exec_core i_exec_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst         (inst),
        .inst_valid   (inst_valid),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_wen   (retire_wen),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .ebreak       (ebreak),
        .illegal      (illegal)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input xlen_t got, input xlen_t want);
        if (got !== want) begin
            abort_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, want));
        end
    endtask

    function automatic xlen_t sext(input xlen_t v, input int bits);
        xlen_t up;
        up = v << (`XLEN - bits);
        return xlen_t'($signed(up) >>> (`XLEN - bits));
    endfunction

    function automatic inst_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                    input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic inst_t enc_j(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic inst_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic reg_addr_t random_reg();
        if ($urandom_range(0, 3) == 0) begin
            return reg_addr_t'($urandom_range(0, 31));
        end
        return reg_addr_t'($urandom_range(0, 7));   // small set, more reuse and x0 hits
    endfunction

    // encodings outside the kept set
    function automatic inst_t bad_inst(input reg_addr_t rd, input reg_addr_t rs1,
                                       input reg_addr_t rs2, input logic [31:0] rnd);
        case ($urandom_range(0, 5))
            0:       return enc_i(rnd[11:0], rs1, 3'b011, rd, OP_LOAD);
            1:       return enc_r(rnd[31:25], rs2, rs1, 3'b011, rnd[11:7], OP_STORE);
            2:       return enc_r(7'h01, rs2, rs1, 3'b111, rd, OP_REG);   // remu
            3:       return 32'h0000_0073;                                // ecall
            4:       return enc_i({6'b000000, rnd[5:0]}, rs1, 3'b001, rd, OP_IMM);
            default: return enc_r(7'h20, rs2, rs1, 3'b000, rd, OP_REG32);
        endcase
    endfunction

    function automatic inst_t make_inst();
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   br_rs2;
        logic [31:0] rnd;
        inst_t       ins;
        rd     = random_reg();
        rs1    = random_reg();
        rs2    = random_reg();
        rnd    = $urandom;
        br_rs2 = ($urandom_range(0, 2) == 0) ? rs1 : rs2;   // force equal operands now and then
        case ($urandom_range(0, 21))
            0:       ins = enc_r(7'h00, rs2, rs1, 3'b000, rd, OP_REG);
            1:       ins = enc_r(7'h20, rs2, rs1, 3'b000, rd, OP_REG);
            2:       ins = enc_r(7'h00, rs2, rs1, 3'b111, rd, OP_REG);
            3:       ins = enc_r(7'h00, rs2, rs1, 3'b011, rd, OP_REG);
            4:       ins = enc_i(rnd[11:0], rs1, 3'b000, rd, OP_IMM);
            5:       ins = enc_i(rnd[11:0], rs1, 3'b011, rd, OP_IMM);
            6:       ins = enc_i(rnd[11:0], rs1, 3'b111, rd, OP_IMM);
            7:       ins = enc_i(rnd[11:0], rs1, 3'b100, rd, OP_IMM);
            8:       ins = enc_i({6'b000000, rnd[5:0]}, rs1, 3'b101, rd, OP_IMM);
            9:       ins = enc_i({6'b010000, rnd[5:0]}, rs1, 3'b101, rd, OP_IMM);
            10:      ins = enc_r(7'h00, rs2, rs1, 3'b000, rd, OP_REG32);
            11:      ins = enc_r(7'h00, rs2, rs1, 3'b001, rd, OP_REG32);
            12:      ins = enc_i(rnd[11:0], rs1, 3'b000, rd, OP_IMM32);
            13:      ins = enc_u(rnd[31:12], rd, OP_LUI);
            14:      ins = enc_u(rnd[31:12], rd, OP_AUIPC);
            15:      ins = enc_j({rnd[20:1], 1'b0}, rd);
            16:      ins = enc_i(rnd[11:0], rs1, 3'b000, rd, OP_JALR);
            17:      ins = enc_b({rnd[12:1], 1'b0}, br_rs2, rs1, 3'b000);
            18:      ins = enc_b({rnd[12:1], 1'b0}, br_rs2, rs1, 3'b001);
            19:      ins = 32'h0010_0073;   // ebreak
            20:      ins = bad_inst(rd, rs1, rs2, rnd);
            default: ins = rnd;             // raw word
        endcase
        return ins;
    endfunction

    // expected retire record from the architectural rules
    function automatic retire_rec_t predict(input inst_t ins);
        retire_rec_t r;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        xlen_t       a;
        xlen_t       b;
        xlen_t       imm_i;
        xlen_t       imm_u;
        xlen_t       imm_j;
        xlen_t       imm_b;
        xlen_t       val;
        logic        writes;
        opc    = ins[6:0];
        f3     = ins[14:12];
        f7     = ins[31:25];
        a      = model_regs[ins[19:15]];
        b      = model_regs[ins[24:20]];
        imm_i  = sext(xlen_t'(ins[31:20]), 12);
        imm_u  = sext(xlen_t'({ins[31:12], 12'b0}), 32);
        imm_j  = sext(xlen_t'({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}), 21);
        imm_b  = sext(xlen_t'({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}), 13);
        r         = '0;
        r.pc      = model_pc;
        r.next_pc = model_pc + 64'd4;
        r.rd      = ins[11:7];
        val       = '0;
        writes    = 1'b0;
        case (opc)
            OP_REG: begin
                writes = 1'b1;
                if (f7 == 7'h00 && f3 == 3'b000) begin
                    val = a + b;
                end else if (f7 == 7'h20 && f3 == 3'b000) begin
                    val = a - b;
                end else if (f7 == 7'h00 && f3 == 3'b011) begin
                    val = (a < b) ? 64'd1 : 64'd0;
                end else if (f7 == 7'h00 && f3 == 3'b111) begin
                    val = a & b;
                end else begin
                    writes    = 1'b0;
                    r.illegal = 1'b1;
                end
            end
            OP_IMM: begin
                writes = 1'b1;
                case (f3)
                    3'b000:  val = a + imm_i;
                    3'b011:  val = (a < imm_i) ? 64'd1 : 64'd0;
                    3'b100:  val = a ^ imm_i;
                    3'b111:  val = a & imm_i;
                    3'b101: begin
                        if (ins[31:26] == 6'b000000) begin
                            val = a >> ins[25:20];
                        end else if (ins[31:26] == 6'b010000) begin
                            val = xlen_t'($signed(a) >>> ins[25:20]);
                        end else begin
                            writes    = 1'b0;
                            r.illegal = 1'b1;
                        end
                    end
                    default: begin
                        writes    = 1'b0;
                        r.illegal = 1'b1;
                    end
                endcase
            end
            OP_REG32: begin
                if (f7 == 7'h00 && f3 == 3'b000) begin
                    writes = 1'b1;
                    val    = sext(a + b, 32);
                end else if (f7 == 7'h00 && f3 == 3'b001) begin
                    writes = 1'b1;
                    val    = sext(a << b[4:0], 32);
                end else begin
                    r.illegal = 1'b1;
                end
            end
            OP_IMM32: begin
                writes    = (f3 == 3'b000);
                r.illegal = !writes;
                val       = sext(a + imm_i, 32);
            end
            OP_LUI: begin
                writes = 1'b1;
                val    = imm_u;
            end
            OP_AUIPC: begin
                writes = 1'b1;
                val    = model_pc + imm_u;
            end
            OP_JAL: begin
                writes    = 1'b1;
                val       = model_pc + 64'd4;
                r.next_pc = model_pc + imm_j;
            end
            OP_JALR: begin
                if (f3 == 3'b000) begin
                    writes    = 1'b1;
                    val       = model_pc + 64'd4;
                    r.next_pc = (a + imm_i) & ~64'd1;
                end else begin
                    r.illegal = 1'b1;
                end
            end
            OP_BRANCH: begin
                if (f3 == 3'b000) begin
                    r.next_pc = (a == b) ? model_pc + imm_b : model_pc + 64'd4;
                end else if (f3 == 3'b001) begin
                    r.next_pc = (a != b) ? model_pc + imm_b : model_pc + 64'd4;
                end else begin
                    r.illegal = 1'b1;
                end
            end
            OP_SYSTEM: begin
                r.ebreak  = (ins == 32'h0010_0073);
                r.illegal = !r.ebreak;
            end
            default: r.illegal = 1'b1;
        endcase
        r.wen  = writes && (r.rd != '0);
        r.data = val;
        return r;
    endfunction

    initial begin : drive
        retire_rec_t rec;
        inst_t       ins;
        void'($urandom(32'h815f));
        inst       = '0;
        inst_valid = 1'b0;
        model_pc   = `RESET_PC;
        issued     = 0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        @(posedge rst_n);
        @(negedge clk);
        check_value("pc", pc, `RESET_PC);
        check_value("retire_valid", xlen_t'(retire_valid), '0);
        check_value("ebreak", xlen_t'(ebreak), '0);
        check_value("illegal", xlen_t'(illegal), '0);
        while (issued < NUM_INSTS) begin
            @(posedge clk);
            if ($urandom_range(0, 99) < IDLE_PCT) begin
                inst       <= $urandom;   // ignored by the DUT
                inst_valid <= 1'b0;
            end else begin
                ins = make_inst();
                rec = predict(ins);
                if (rec.wen) begin
                    model_regs[rec.rd] = rec.data;
                end
                model_pc = rec.next_pc;
                pending.push_back(rec);
                inst       <= ins;
                inst_valid <= 1'b1;
                issued++;
            end
        end
        @(posedge clk);
        inst_valid <= 1'b0;
        repeat (3) @(posedge clk);
        if (pending.size() == 0 && checked == issued) begin
            $display("sim passed");
            $finish;
        end else begin
            abort_run($sformatf("%0d instructions issued but only %0d retired", issued, checked));
        end
    end

    // retire outputs are stable at the falling edge
    initial begin : compare
        retire_rec_t want;
        xlen_t       cur_pc;
        cur_pc  = `RESET_PC;
        checked = 0;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            if (retire_valid) begin
                if (pending.size() == 0) begin
                    abort_run("retire_valid went high with no instruction outstanding");
                end else begin
                    want = pending.pop_front();
                    check_value("retire_pc", retire_pc, want.pc);
                    check_value("retire_wen", xlen_t'(retire_wen), xlen_t'(want.wen));
                    check_value("ebreak", xlen_t'(ebreak), xlen_t'(want.ebreak));
                    check_value("illegal", xlen_t'(illegal), xlen_t'(want.illegal));
                    check_value("pc", pc, want.next_pc);
                    if (want.wen) begin
                        check_value("retire_rd", xlen_t'(retire_rd), xlen_t'(want.rd));
                        check_value("retire_data", retire_data, want.data);
                    end
                    cur_pc = want.next_pc;
                    checked++;
                end
            end else begin
                check_value("pc", pc, cur_pc);   // idle holds pc
                check_value("retire_wen", xlen_t'(retire_wen), '0);
                check_value("ebreak", xlen_t'(ebreak), '0);
                check_value("illegal", xlen_t'(illegal), '0);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_TIME);
        abort_run($sformatf("timeout after %0d time units, the run hung", WATCHDOG_TIME));
    end

endmodule

`default_nettype wire

/* tests/clk_gen.sv */
`default_nettype none

module clk_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;   // release on an edge
    end

endmodule

`default_nettype wire

/* source/exec_core.sv */
`default_nettype none

module exec_core import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  inst_t     inst,
    input  logic      inst_valid,
    output xlen_t     pc,
    output logic      retire_valid,
    output xlen_t     retire_pc,
    output logic      retire_wen,
    output reg_addr_t retire_rd,
    output xlen_t     retire_data,
    output logic      ebreak,
    output logic      illegal
);

    logic      reg_wen;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    imm_sel_e  imm_sel;
    alu_op_e   alu_op;
    alu_src_e  alu_src;
    logic      word_op;
    br_cond_e  br_cond;
    logic      jump;
    logic      jalr;
    logic      ebreak_hit;
    logic      illegal_hit;
    xlen_t     imm;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    logic      wen;
    reg_addr_t waddr;
    xlen_t     wdata;

    ctrl i_ctrl (
        .inst        (inst),
        .reg_wen     (reg_wen),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rd_addr     (rd_addr),
        .imm_sel     (imm_sel),
        .alu_op      (alu_op),
        .alu_src     (alu_src),
        .word_op     (word_op),
        .br_cond     (br_cond),
        .jump        (jump),
        .jalr        (jalr),
        .ebreak_hit  (ebreak_hit),
        .illegal_hit (illegal_hit)
    );

    imm_gen i_imm_gen (
        .inst    (inst),
        .imm_sel (imm_sel),
        .imm     (imm)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .waddr    (waddr),
        .wen      (wen),
        .wdata    (wdata),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exec_unit i_exec_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .reg_wen      (reg_wen),
        .rd_addr      (rd_addr),
        .alu_op       (alu_op),
        .alu_src      (alu_src),
        .word_op      (word_op),
        .br_cond      (br_cond),
        .jump         (jump),
        .jalr         (jalr),
        .ebreak_hit   (ebreak_hit),
        .illegal_hit  (illegal_hit),
        .imm          (imm),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .wen          (wen),
        .waddr        (waddr),
        .wdata        (wdata),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_wen   (retire_wen),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .ebreak       (ebreak),
        .illegal      (illegal)
    );

endmodule

`default_nettype wire

/* source/exec_unit.sv */
`default_nettype none

`include "rv_config.svh"

module exec_unit import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      inst_valid,
    input  logic      reg_wen,
    input  reg_addr_t rd_addr,
    input  alu_op_e   alu_op,
    input  alu_src_e  alu_src,
    input  logic      word_op,
    input  br_cond_e  br_cond,
    input  logic      jump,
    input  logic      jalr,
    input  logic      ebreak_hit,
    input  logic      illegal_hit,
    input  xlen_t     imm,
    input  xlen_t     rs1_data,
    input  xlen_t     rs2_data,
    output logic      wen,
    output reg_addr_t waddr,
    output xlen_t     wdata,
    output xlen_t     pc,
    output logic      retire_valid,
    output xlen_t     retire_pc,
    output logic      retire_wen,
    output reg_addr_t retire_rd,
    output xlen_t     retire_data,
    output logic      ebreak,
    output logic      illegal
);

    xlen_t      op_a;
    xlen_t      op_b;
    xlen_t      alu_out;
    xlen_t      result;
    logic [5:0] shamt;
    logic       br_taken;
    xlen_t      next_pc;

    always_comb begin
        case (alu_src)
            SRC_REG:     begin op_a = rs1_data; op_b = rs2_data; end
            SRC_IMM:     begin op_a = rs1_data; op_b = imm;      end
            SRC_IMM_PC:  begin op_a = pc;       op_b = imm;      end
            default:     begin op_a = pc;       op_b = 64'd4;    end
        endcase
    end

    assign shamt = word_op ? {1'b0, op_b[4:0]} : op_b[5:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_out = op_a + op_b;
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_AND:  alu_out = op_a & op_b;
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_SLTU: alu_out = {{(`XLEN-1){1'b0}}, (op_a < op_b)};
            ALU_SRL:  alu_out = op_a >> shamt;
            ALU_SRA:  alu_out = $signed(op_a) >>> shamt;
            default:  alu_out = op_a << shamt;
        endcase
    end

    // *w ops keep the low word, sign extended
    assign result = word_op ? {{(`XLEN-32){alu_out[31]}}, alu_out[31:0]} : alu_out;

    assign br_taken = ((br_cond == BR_EQ) && (rs1_data == rs2_data)) ||
                      ((br_cond == BR_NE) && (rs1_data != rs2_data));

    always_comb begin
        if (jalr) begin
            next_pc = (rs1_data + imm) & ~64'd1;
        end else if (jump || br_taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + 64'd4;
        end
    end

    assign wen   = inst_valid && reg_wen && (rd_addr != '0);   // x0 writes dropped
    assign waddr = rd_addr;
    assign wdata = result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc           <= `RESET_PC;
            retire_valid <= 1'b0;
            retire_wen   <= 1'b0;
            ebreak       <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            retire_valid <= inst_valid;
            retire_wen   <= wen;
            ebreak       <= inst_valid && ebreak_hit;
            illegal      <= inst_valid && illegal_hit;
            if (inst_valid) begin
                pc <= next_pc;
            end
        end
    end

    // retire payload
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            retire_pc   <= pc;
            retire_rd   <= rd_addr;
            retire_data <= result;
        end
    end

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[0] == 1'b0);

    // decoder keeps trapping encodings off the write port
    no_retire_write_on_trap: assert property (
        @(posedge clk) disable iff (!rst_n) (ebreak || illegal) |-> !retire_wen);

endmodule

`default_nettype wire

/* source/reg_file.sv */
`default_nettype none

`include "rv_config.svh"

module reg_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  reg_addr_t waddr,
    input  logic      wen,
    input  xlen_t     wdata,
    output xlen_t     rs1_data,
    output xlen_t     rs2_data
);

    xlen_t regs [`NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero regardless of contents
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* source/imm_gen.sv */
`default_nettype none

`include "rv_config.svh"

module imm_gen import rv_pkg::*; (
    input  inst_t    inst,
    input  imm_sel_e imm_sel,
    output xlen_t    imm
);

    logic  sign;
    xlen_t imm_i;
    xlen_t imm_u;
    xlen_t imm_j;
    xlen_t imm_b;

    assign sign = inst[31];

    assign imm_i = {{(`XLEN-12){sign}}, inst[31:20]};
    assign imm_u = {{(`XLEN-32){sign}}, inst[31:12], 12'b0};
    // scrambled jal / branch offsets, bit 0 implied zero
    assign imm_j = {{(`XLEN-20){sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{(`XLEN-12){sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        case (imm_sel)
            IMM_I:   imm = imm_i;
            IMM_U:   imm = imm_u;
            IMM_J:   imm = imm_j;
            IMM_B:   imm = imm_b;
            default: imm = imm_i;
        endcase
    end

endmodule

`default_nettype wire

/* source/ctrl.sv */
`default_nettype none

module ctrl import rv_pkg::*; (
    input  inst_t     inst,
    output logic      reg_wen,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output reg_addr_t rd_addr,
    output imm_sel_e  imm_sel,
    output alu_op_e   alu_op,
    output alu_src_e  alu_src,
    output logic      word_op,
    output br_cond_e  br_cond,
    output logic      jump,
    output logic      jalr,
    output logic      ebreak_hit,
    output logic      illegal_hit
);

    localparam opcode_t OPC_OP         = 7'b0110011;
    localparam opcode_t OPC_OP_IMM     = 7'b0010011;
    localparam opcode_t OPC_OP_32      = 7'b0111011;
    localparam opcode_t OPC_OP_IMM_32  = 7'b0011011;
    localparam opcode_t OPC_LUI        = 7'b0110111;
    localparam opcode_t OPC_AUIPC      = 7'b0010111;
    localparam opcode_t OPC_JAL        = 7'b1101111;
    localparam opcode_t OPC_JALR       = 7'b1100111;
    localparam opcode_t OPC_BRANCH     = 7'b1100011;
    localparam opcode_t OPC_SYSTEM     = 7'b1110011;
    localparam inst_t   EBREAK_INST    = 32'h0010_0073;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        reg_wen     = 1'b0;
        rs1_addr    = '0;
        rs2_addr    = '0;
        rd_addr     = '0;
        imm_sel     = IMM_I;
        alu_op      = ALU_ADD;
        alu_src     = SRC_REG;
        word_op     = 1'b0;
        br_cond     = BR_NONE;
        jump        = 1'b0;
        jalr        = 1'b0;
        ebreak_hit  = 1'b0;
        illegal_hit = 1'b0;
        case (opcode)
            OPC_OP: begin
                rs1_addr = rs1;
                rs2_addr = rs2;
                rd_addr  = rd;
                case (funct3)
                    3'b000: begin
                        if (funct7 == 7'b0000000) begin
                            alu_op  = ALU_ADD;
                            reg_wen = 1'b1;
                        end else if (funct7 == 7'b0100000) begin
                            alu_op  = ALU_SUB;
                            reg_wen = 1'b1;
                        end else begin
                            illegal_hit = 1'b1;
                        end
                    end
                    3'b011: begin
                        alu_op = ALU_SLTU;
                        if (funct7 == 7'b0000000) begin
                            reg_wen = 1'b1;
                        end else begin
                            illegal_hit = 1'b1;
                        end
                    end
                    3'b111: begin
                        alu_op = ALU_AND;
                        if (funct7 == 7'b0000000) begin
                            reg_wen = 1'b1;
                        end else begin
                            illegal_hit = 1'b1;   // remu not kept
                        end
                    end
                    default: illegal_hit = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                rs1_addr = rs1;
                rd_addr  = rd;
                alu_src  = SRC_IMM;
                reg_wen  = 1'b1;
                case (funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b011:  alu_op = ALU_SLTU;
                    3'b100:  alu_op = ALU_XOR;
                    3'b111:  alu_op = ALU_AND;
                    3'b101: begin
                        if (inst[31:26] == 6'b000000) begin
                            alu_op = ALU_SRL;
                        end else if (inst[31:26] == 6'b010000) begin
                            alu_op = ALU_SRA;
                        end else begin
                            reg_wen     = 1'b0;
                            illegal_hit = 1'b1;
                        end
                    end
                    default: begin
                        reg_wen     = 1'b0;
                        illegal_hit = 1'b1;
                    end
                endcase
            end
            OPC_OP_32: begin
                rs1_addr = rs1;
                rs2_addr = rs2;
                rd_addr  = rd;
                word_op  = 1'b1;
                alu_op   = (funct3 == 3'b001) ? ALU_SLL : ALU_ADD;
                if ((funct7 == 7'b0000000) && (funct3[2:1] == 2'b00)) begin
                    reg_wen = 1'b1;
                end else begin
                    illegal_hit = 1'b1;
                end
            end
            OPC_OP_IMM_32: begin
                rs1_addr = rs1;
                rd_addr  = rd;
                alu_src  = SRC_IMM;
                word_op  = 1'b1;
                if (funct3 == 3'b000) begin
                    reg_wen = 1'b1;   // addiw only
                end else begin
                    illegal_hit = 1'b1;
                end
            end
            OPC_LUI: begin
                rd_addr = rd;                // x0 + imm
                imm_sel = IMM_U;
                alu_src = SRC_IMM;
                reg_wen = 1'b1;
            end
            OPC_AUIPC: begin
                rd_addr = rd;
                imm_sel = IMM_U;
                alu_src = SRC_IMM_PC;
                reg_wen = 1'b1;
            end
            OPC_JAL: begin
                rd_addr = rd;
                imm_sel = IMM_J;
                alu_src = SRC_FOUR_PC;       // link value
                jump    = 1'b1;
                reg_wen = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    rs1_addr = rs1;
                    rd_addr  = rd;
                    alu_src  = SRC_FOUR_PC;
                    jump     = 1'b1;
                    jalr     = 1'b1;
                    reg_wen  = 1'b1;
                end else begin
                    illegal_hit = 1'b1;
                end
            end
            OPC_BRANCH: begin
                rs1_addr = rs1;
                rs2_addr = rs2;
                imm_sel  = IMM_B;
                alu_op   = ALU_SUB;
                case (funct3)
                    3'b000:  br_cond = BR_EQ;
                    3'b001:  br_cond = BR_NE;
                    default: illegal_hit = 1'b1;
                endcase
            end
            OPC_SYSTEM: begin
                ebreak_hit  = (inst == EBREAK_INST);
                illegal_hit = !ebreak_hit;   // no csr / ecall here
            end
            default: illegal_hit = 1'b1;
        endcase
    end

    always_comb begin
        no_write_on_illegal: assert (!(illegal_hit && reg_wen));
    end

endmodule

`default_nettype wire

/* source/rv_pkg.sv */
`default_nettype none

`include "rv_config.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0]       xlen_t;      // register / result value
    typedef logic [`INST_W-1:0]     inst_t;      // raw instruction word
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;  // x0..x31
    typedef logic [`OPCODE_W-1:0]   opcode_t;    // inst[6:0]

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_XOR,
        ALU_SLTU,
        ALU_SRL,
        ALU_SRA,
        ALU_SLL
    } alu_op_e;

    // operand b and addition base
    typedef enum logic [1:0] {
        SRC_REG,      // rs1 op rs2
        SRC_IMM,      // rs1 op imm
        SRC_IMM_PC,   // pc + imm
        SRC_FOUR_PC   // pc + 4
    } alu_src_e;

    typedef enum logic [1:0] {
        IMM_I,
        IMM_U,
        IMM_J,
        IMM_B
    } imm_sel_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } br_cond_e;

endpackage

`default_nettype wire

/* include/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// datapath widths
`define XLEN        64
`define INST_W      32
`define REG_ADDR_W  5
`define OPCODE_W    7

// architectural register count
`define NUM_REGS    32

// first fetch address after reset
`define RESET_PC    64'h8000_0000

`endif
